// File: sources.f
hdl/riscboy_pkg.sv
hdl/apb_splitter.sv
hdl/gpio.sv
hdl/pwm_tiny.sv
hdl/riscboy_periph.sv
testbench/periph_checker.sv
testbench/tb_riscboy_periph.sv

// File: Makefile
# Verilator build and run for the peripheral subsystem testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= tb_riscboy_periph
FILELIST  ?= sources.f

.PHONY: sim clean

# Build, run, and pass only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir

// File: testbench/tb_riscboy_periph.sv
// ==============================
// Testbench for the peripheral subsystem, table driven APB
// master with a management port slave that adds wait states
// ==============================

`timescale 1ns/1ps
`default_nettype none

module tb_riscboy_periph;

localparam int N_PADS = 11;

typedef struct packed {
	logic              wr;
	logic [15:0]       addr;
	logic [31:0]       wdata;
	logic [N_PADS-1:0] pin;
	logic [31:0]       rdata;
	logic              slverr;
	logic [15:0]       window;
} entry_t;

logic                   clk_sys;
logic                   rst;
riscboy_pkg::apb_req_t  apbs_req;
riscboy_pkg::apb_resp_t apbs_resp;
riscboy_pkg::apb_req_t  tbio_req;
riscboy_pkg::apb_resp_t tbio_resp;
logic [N_PADS-1:0]      padin;
wire  [N_PADS-1:0]      padout;
wire  [N_PADS-1:0]      padoe;
wire                    lcd_pwm;

logic                   exp_valid;
logic [31:0]            exp_rdata;
logic                   exp_slverr;
int                     pwm_window;
int                     errors;
int                     checks;
int                     tbio_errors;

entry_t                 table_q[$];
bit                     table_ready;
logic [31:0]            tbio_mem [16];
integer                 seed = 32'h34640af3;

riscboy_periph #(
	.N_PADS (N_PADS)
) uut (
	.clk_sys   (clk_sys),
	.rst       (rst),
	.apbs_req  (apbs_req),
	.apbs_resp (apbs_resp),
	.tbio_req  (tbio_req),
	.tbio_resp (tbio_resp),
	.padout    (padout),
	.padoe     (padoe),
	.padin     (padin),
	.lcd_pwm   (lcd_pwm)
);

periph_checker #(
	.N_PADS (N_PADS)
) inst_checker (
	.clk_sys    (clk_sys),
	.rst        (rst),
	.apbs_req   (apbs_req),
	.apbs_resp  (apbs_resp),
	.padout     (padout),
	.padoe      (padoe),
	.lcd_pwm    (lcd_pwm),
	.exp_valid  (exp_valid),
	.exp_rdata  (exp_rdata),
	.exp_slverr (exp_slverr),
	.pwm_window (pwm_window),
	.errors     (errors),
	.checks     (checks)
);

initial begin
	clk_sys = 1'b0;
	forever #5 clk_sys = ~clk_sys;
end

task automatic add_entry(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
	input logic [N_PADS-1:0] pin, input logic [31:0] rdata, input logic slverr,
	input logic [15:0] window);
	entry_t e;
	e = {wr, addr, wdata, pin, rdata, slverr, window};
	table_q.push_back(e);
endtask

// ==============================
// Transaction table
// ==============================

task automatic build_table();
	// Reset values, PWM output low while disabled
	add_entry(1'b0, 16'h0000, 32'h0, 11'h000, 32'h0, 1'b0, 16'd0);
	add_entry(1'b0, 16'h0004, 32'h0, 11'h000, 32'h0, 1'b0, 16'd0);
	add_entry(1'b0, 16'h0008, 32'h0, 11'h000, 32'h0, 1'b0, 16'd0);
	add_entry(1'b0, 16'h1000, 32'h0, 11'h000, 32'h0, 1'b0, 16'd32);
	add_entry(1'b0, 16'h1004, 32'h0, 11'h000, 32'h0, 1'b0, 16'd0);
	add_entry(1'b0, 16'h1008, 32'h0, 11'h000, 32'h0, 1'b0, 16'd0);
	// GPIO registers and the synchronized input
	add_entry(1'b1, 16'h0000, 32'h5a5, 11'h000, 32'h0, 1'b0, 16'd0);
	add_entry(1'b1, 16'h0004, 32'h7ff, 11'h000, 32'h0, 1'b0, 16'd0);
	add_entry(1'b0, 16'h0000, 32'h0, 11'h000, 32'h5a5, 1'b0, 16'd0);
	add_entry(1'b0, 16'h0004, 32'h0, 11'h000, 32'h7ff, 1'b0, 16'd0);
	add_entry(1'b1, 16'h0000, 32'hfffff0f3, 11'h3c6, 32'h0, 1'b0, 16'd0);
	add_entry(1'b0, 16'h0008, 32'h0, 11'h3c6, 32'h3c6, 1'b0, 16'd0);
	add_entry(1'b1, 16'h0008, 32'h123, 11'h3c6, 32'h0, 1'b1, 16'd0);
	add_entry(1'b0, 16'h000c, 32'h0, 11'h3c6, 32'h0, 1'b1, 16'd0);
	add_entry(1'b0, 16'h0000, 32'h0, 11'h3c6, 32'h0f3, 1'b0, 16'd0);
	// Unmapped slots
	add_entry(1'b0, 16'h2000, 32'h0, 11'h3c6, 32'h0, 1'b1, 16'd0);
	add_entry(1'b1, 16'h7abc, 32'h11111111, 11'h3c6, 32'h0, 1'b1, 16'd0);
	add_entry(1'b0, 16'he004, 32'h0, 11'h3c6, 32'h0, 1'b1, 16'd0);
	// Management port with random wait states
	add_entry(1'b1, 16'hf000, 32'hcafe0001, 11'h3c6, 32'h0, 1'b0, 16'd0);
	add_entry(1'b1, 16'hf03c, 32'h0badf00d, 11'h3c6, 32'h0, 1'b0, 16'd0);
	add_entry(1'b0, 16'hf000, 32'h0, 11'h3c6, 32'hcafe0001, 1'b0, 16'd0);
	add_entry(1'b0, 16'hf03c, 32'h0, 11'h3c6, 32'h0badf00d, 1'b0, 16'd0);
	add_entry(1'b1, 16'hf000, 32'h13572468, 11'h3c6, 32'h0, 1'b0, 16'd0);
	add_entry(1'b0, 16'hf000, 32'h0, 11'h3c6, 32'h13572468, 1'b0, 16'd0);
	// PWM with DIV 1 and CMP 64, plain, inverted, then disabled inverted
	add_entry(1'b1, 16'h1004, 32'h1, 11'h3c6, 32'h0, 1'b0, 16'd0);
	add_entry(1'b1, 16'h1008, 32'h40, 11'h3c6, 32'h0, 1'b0, 16'd0);
	add_entry(1'b1, 16'h100c, 32'h5, 11'h3c6, 32'h0, 1'b1, 16'd0);
	add_entry(1'b1, 16'h1000, 32'h1, 11'h3c6, 32'h0, 1'b0, 16'd0);
	add_entry(1'b0, 16'h1000, 32'h0, 11'h3c6, 32'h1, 1'b0, 16'd512);
	add_entry(1'b1, 16'h1000, 32'h3, 11'h3c6, 32'h0, 1'b0, 16'd0);
	add_entry(1'b0, 16'h1000, 32'h0, 11'h3c6, 32'h3, 1'b0, 16'd512);
	add_entry(1'b1, 16'h1000, 32'h2, 11'h3c6, 32'h0, 1'b0, 16'd0);
	add_entry(1'b0, 16'h1008, 32'h0, 11'h3c6, 32'h40, 1'b0, 16'd64);
endtask

// One APB transfer, an idle cycle, then the PWM window if the entry has one
task automatic apply_entry(input entry_t e);
	apbs_req.paddr   = e.addr;
	apbs_req.pwrite  = e.wr;
	apbs_req.pwdata  = e.wdata;
	apbs_req.psel    = 1'b1;
	apbs_req.penable = 1'b0;
	padin            = e.pin;
	exp_valid        = 1'b1;
	exp_rdata        = e.rdata;
	exp_slverr       = e.slverr;
	pwm_window       = int'(e.window);
	@(posedge clk_sys);
	#1;
	apbs_req.penable = 1'b1;
	@(posedge clk_sys);
	while (!apbs_resp.pready)
		@(posedge clk_sys);
	#1;
	apbs_req.psel    = 1'b0;
	apbs_req.penable = 1'b0;
	exp_valid        = 1'b0;
	repeat (1 + int'(e.window)) @(posedge clk_sys);
	#1;
endtask

// ==============================
// Management port slave
// ==============================

initial begin : tbio_slave
	riscboy_pkg::apb_req_t req;
	logic                  done;
	int                    wait_cnt;
	int                    i;
	for (i = 0; i < 16; i++)
		tbio_mem[i] = 32'h7b5e0000 + i;
	tbio_resp = '0;
	wait_cnt  = 0;
	forever begin
		@(posedge clk_sys);
		req  = tbio_req;
		done = req.psel && req.penable && tbio_resp.pready;
		// Only slot 0xf addresses may reach the management port
		if (req.psel && req.paddr[15:12] != 4'hf) begin
			$display("management port selected by an access to %h", req.paddr);
			tbio_errors++;
		end
		#1;
		if (done) begin
			if (req.pwrite)
				tbio_mem[req.paddr[5:2]] = req.pwdata;
			tbio_resp = '0;
		end else if (req.psel) begin
			// Setup draws 0 to 3 wait states, each access cycle uses one up
			if (!req.penable)
				wait_cnt = $random(seed) & 3;
			else
				wait_cnt--;
			tbio_resp.pready = wait_cnt == 0;
			tbio_resp.prdata = wait_cnt == 0 ? tbio_mem[req.paddr[5:2]] : '0;
		end
	end
end

initial begin : watchdog
	int limit;
	wait (table_ready);
	limit = 16 + 6 * table_q.size() + 100;
	foreach (table_q[k])
		limit += int'(table_q[k].window);
	#(limit * 10);
	$display("timeout: the run did not finish within %0d cycles", limit);
	$display("STATUS: FAIL");
	$finish;
end

initial begin : main
	rst        = 1'b1;
	apbs_req   = '0;
	padin      = '0;
	exp_valid  = 1'b0;
	exp_rdata  = '0;
	exp_slverr = 1'b0;
	pwm_window = 0;
	build_table();
	table_ready = 1'b1;
	repeat (16) @(posedge clk_sys);
	#1;
	rst = 1'b0;
	foreach (table_q[n])
		apply_entry(table_q[n]);
	repeat (2) @(posedge clk_sys);
	if (checks != table_q.size())
		$display("only %0d of %0d transfers were checked", checks, table_q.size());
	$display("checked %0d of %0d transfers, %0d errors", checks, table_q.size(),
		errors + tbio_errors);
	if (errors == 0 && tbio_errors == 0 && checks == table_q.size()) begin
		$display("STATUS: PASS");
	end else begin
		$display("STATUS: FAIL");
	end
	$finish;
end

endmodule

`default_nettype wire

// File: testbench/periph_checker.sv
// ==============================
// Bus and pad monitor, compares responses, pads and PWM duty
// ==============================

`timescale 1ns/1ps
`default_nettype none

module periph_checker #(
	parameter int N_PADS = 11
) (
	input  wire                    clk_sys,
	input  wire                    rst,
	input  riscboy_pkg::apb_req_t  apbs_req,
	input  riscboy_pkg::apb_resp_t apbs_resp,
	input  wire  [N_PADS-1:0]      padout,
	input  wire  [N_PADS-1:0]      padoe,
	input  wire                    lcd_pwm,
	// Expectations for the transfer that is on the bus now
	input  wire                    exp_valid,
	input  wire  [31:0]            exp_rdata,
	input  wire                    exp_slverr,
	input  int                     pwm_window,
	output int                     errors,
	output int                     checks
);

// Reference copy of the registers, updated from completed writes
logic [N_PADS-1:0] ref_out;
logic [N_PADS-1:0] ref_oe;
logic              ref_en;
logic              ref_inv;
logic [7:0]        ref_div;
logic [7:0]        ref_cmp;
int                win_left;
int                high_cnt;
int                high_exp;
logic              done;

assign done = apbs_req.psel && apbs_req.penable && apbs_resp.pready;

// High cycles over a window, a whole number of 256 * (DIV+1) periods when enabled
function automatic int expected_high(input int window);
	int period;
	int high;
	period = 256 * (int'(ref_div) + 1);
	if (!ref_en) begin
		high = ref_inv ? window : 0;
	end else begin
		high = int'(ref_cmp) * (int'(ref_div) + 1) * (window / period);
		if (ref_inv)
			high = window - high;
	end
	return high;
endfunction

task automatic record_write();
	logic [11:0] offset;
	offset = apbs_req.paddr[11:0];
	if (apbs_req.paddr[15:12] == riscboy_pkg::SLOT_GPIO) begin
		if (offset == riscboy_pkg::GPIO_OUT)
			ref_out = apbs_req.pwdata[N_PADS-1:0];
		if (offset == riscboy_pkg::GPIO_OE)
			ref_oe = apbs_req.pwdata[N_PADS-1:0];
	end
	if (apbs_req.paddr[15:12] == riscboy_pkg::SLOT_PWM) begin
		if (offset == riscboy_pkg::PWM_CTRL) begin
			ref_en  = apbs_req.pwdata[riscboy_pkg::PWM_CTRL_EN_BIT];
			ref_inv = apbs_req.pwdata[riscboy_pkg::PWM_CTRL_INV_BIT];
		end
		if (offset == riscboy_pkg::PWM_DIV)
			ref_div = apbs_req.pwdata[7:0];
		if (offset == riscboy_pkg::PWM_CMP)
			ref_cmp = apbs_req.pwdata[7:0];
	end
endtask

task automatic check_transfer();
	if (!exp_valid) begin
		$display("a transfer to %h completed with no expectation set", apbs_req.paddr);
		errors++;
		return;
	end
	checks++;
	if (apbs_resp.pslverr !== exp_slverr) begin
		$display("mismatch at %0t: %h pslverr %b, expected %b", $time, apbs_req.paddr,
			apbs_resp.pslverr, exp_slverr);
		errors++;
	end
	if (!apbs_req.pwrite && apbs_resp.prdata !== exp_rdata) begin
		$display("mismatch at %0t: read %h gave %h, expected %h", $time, apbs_req.paddr,
			apbs_resp.prdata, exp_rdata);
		errors++;
	end
	if (apbs_req.pwrite)
		record_write();
	if (pwm_window > 0) begin
		if (ref_en && pwm_window % (256 * (int'(ref_div) + 1)) != 0) begin
			$display("PWM window of %0d cycles is not a whole number of periods", pwm_window);
			errors++;
		end
		win_left = pwm_window;
		high_cnt = 0;
		high_exp = expected_high(pwm_window);
	end
endtask

always @(posedge clk_sys) begin
	if (rst) begin
		ref_out  = '0;
		ref_oe   = '0;
		ref_en   = 1'b0;
		ref_inv  = 1'b0;
		ref_div  = '0;
		ref_cmp  = '0;
		win_left = 0;
		high_cnt = 0;
	end else begin
		// Pads are compared before this edge's write lands in the reference
		if (padout !== ref_out) begin
			$display("mismatch at %0t: padout %h, expected %h", $time, padout, ref_out);
			errors++;
		end
		if (padoe !== ref_oe) begin
			$display("mismatch at %0t: padoe %h, expected %h", $time, padoe, ref_oe);
			errors++;
		end
		if (win_left > 0) begin
			if (lcd_pwm)
				high_cnt++;
			win_left--;
			if (win_left == 0 && high_cnt != high_exp) begin
				$display("mismatch at %0t: lcd_pwm high for %0d cycles, expected %0d",
					$time, high_cnt, high_exp);
				errors++;
			end
		end
		if (done)
			check_transfer();
	end
end

endmodule

`default_nettype wire

// File: hdl/riscboy_periph.sv
// ==============================
// Peripheral subsystem top, one APB bus with
// GPIO, backlight PWM and management port
// ==============================

`timescale 1ns/1ps
`default_nettype none

module riscboy_periph #(
	parameter int N_PADS = 11
) (
	input  wire                    clk_sys,
	input  wire                    rst,

	// APB from the external master
	input  riscboy_pkg::apb_req_t  apbs_req,
	output riscboy_pkg::apb_resp_t apbs_resp,

	// Management port, slot 0xf, served outside the core
	output riscboy_pkg::apb_req_t  tbio_req,
	input  riscboy_pkg::apb_resp_t tbio_resp,

	output wire  [N_PADS-1:0]      padout,
	output wire  [N_PADS-1:0]      padoe,
	input  wire  [N_PADS-1:0]      padin,

	output wire                    lcd_pwm
);

riscboy_pkg::apb_req_t  gpio_req;
riscboy_pkg::apb_resp_t gpio_resp;
riscboy_pkg::apb_req_t  pwm_req;
riscboy_pkg::apb_resp_t pwm_resp;

// ==============================
// Bus fabric
// ==============================

apb_splitter inst_apb_splitter (
	.clk_sys   (clk_sys),
	.apbs_req  (apbs_req),
	.apbs_resp (apbs_resp),
	.gpio_req  (gpio_req),
	.gpio_resp (gpio_resp),
	.pwm_req   (pwm_req),
	.pwm_resp  (pwm_resp),
	.tbio_req  (tbio_req),
	.tbio_resp (tbio_resp)
);

// ==============================
// Slaves
// ==============================

gpio #(
	.N_PADS (N_PADS)
) inst_gpio (
	.clk_sys   (clk_sys),
	.rst       (rst),
	.apbs_req  (gpio_req),
	.apbs_resp (gpio_resp),
	.padout    (padout),
	.padoe     (padoe),
	.padin     (padin)
);

pwm_tiny inst_pwm_tiny (
	.clk_sys   (clk_sys),
	.rst       (rst),
	.apbs_req  (pwm_req),
	.apbs_resp (pwm_resp),
	.padout    (lcd_pwm)
);

endmodule

`default_nettype wire

// File: hdl/pwm_tiny.sv
// ==============================
// Backlight PWM with prescaler, counter and compare
// ==============================

`timescale 1ns/1ps
`default_nettype none

module pwm_tiny (
	input  wire                    clk_sys,
	input  wire                    rst,

	input  riscboy_pkg::apb_req_t  apbs_req,
	output riscboy_pkg::apb_resp_t apbs_resp,

	output logic                   padout
);

localparam int W = riscboy_pkg::W_PWM;

logic         ctrl_en;
logic         ctrl_inv;
logic [W-1:0] div;
logic [W-1:0] cmp;
logic [W-1:0] prescale;
logic [W-1:0] ctr;
logic [11:0]  offset;
logic         bad_access;
logic         wen;

assign offset     = apbs_req.paddr[11:0];
assign bad_access = !(offset == riscboy_pkg::PWM_CTRL || offset == riscboy_pkg::PWM_DIV ||
	offset == riscboy_pkg::PWM_CMP);
assign wen = apbs_req.psel && apbs_req.penable && apbs_req.pwrite && !bad_access;

always_ff @(posedge clk_sys) begin
	if (rst) begin
		ctrl_en  <= 1'b0;
		ctrl_inv <= 1'b0;
		div      <= '0;
		cmp      <= '0;
		prescale <= '0;
		ctr      <= '0;
		padout   <= 1'b0;
	end else begin
		if (wen && offset == riscboy_pkg::PWM_CTRL) begin
			ctrl_en  <= apbs_req.pwdata[riscboy_pkg::PWM_CTRL_EN_BIT];
			ctrl_inv <= apbs_req.pwdata[riscboy_pkg::PWM_CTRL_INV_BIT];
		end
		if (wen && offset == riscboy_pkg::PWM_DIV)
			div <= apbs_req.pwdata[W-1:0];
		if (wen && offset == riscboy_pkg::PWM_CMP)
			cmp <= apbs_req.pwdata[W-1:0];
		// A new divider restarts the prescaler so it never runs past DIV
		if (!ctrl_en || (wen && offset == riscboy_pkg::PWM_DIV)) begin
			prescale <= '0;
		end else if (prescale == div) begin
			prescale <= '0;
		end else begin
			prescale <= prescale + 1'b1;
		end
		if (!ctrl_en)
			ctr <= '0;
		else if (prescale == div)
			ctr <= ctr + 1'b1;
		padout <= ctrl_en ? ((ctr < cmp) ^ ctrl_inv) : ctrl_inv;
	end
end

always_comb begin
	apbs_resp.prdata  = '0;
	apbs_resp.pready  = 1'b1;
	apbs_resp.pslverr = bad_access;
	case (offset)
		riscboy_pkg::PWM_CTRL: begin
			apbs_resp.prdata[riscboy_pkg::PWM_CTRL_EN_BIT]  = ctrl_en;
			apbs_resp.prdata[riscboy_pkg::PWM_CTRL_INV_BIT] = ctrl_inv;
		end
		riscboy_pkg::PWM_DIV: apbs_resp.prdata[W-1:0] = div;
		riscboy_pkg::PWM_CMP: apbs_resp.prdata[W-1:0] = cmp;
		default:              apbs_resp.prdata = '0;
	endcase
end

assert property (@(posedge clk_sys) disable iff (rst) ctrl_en |-> prescale <= div)
	else $error("pwm_tiny: prescaler ran past divider");

endmodule

`default_nettype wire

// File: hdl/gpio.sv
// ==============================
// GPIO block with pad output and output enable
// registers and a synchronized pad input
// ==============================

`timescale 1ns/1ps
`default_nettype none

module gpio #(
	parameter int N_PADS = 11
) (
	input  wire                    clk_sys,
	input  wire                    rst,

	input  riscboy_pkg::apb_req_t  apbs_req,
	output riscboy_pkg::apb_resp_t apbs_resp,

	output logic [N_PADS-1:0]      padout,
	output logic [N_PADS-1:0]      padoe,
	input  wire  [N_PADS-1:0]      padin
);

logic [N_PADS-1:0] padin_meta;
logic [N_PADS-1:0] padin_sync;
logic [11:0]       offset;
logic              bad_access;
logic              wen;

assign offset = apbs_req.paddr[11:0];

// GPIO_IN is read-only, anything outside the three offsets is an error
assign bad_access =
	!(offset == riscboy_pkg::GPIO_OUT || offset == riscboy_pkg::GPIO_OE ||
	  offset == riscboy_pkg::GPIO_IN) ||
	(apbs_req.pwrite && offset == riscboy_pkg::GPIO_IN);

assign wen = apbs_req.psel && apbs_req.penable && apbs_req.pwrite && !bad_access;

always_ff @(posedge clk_sys) begin
	if (rst) begin
		padout     <= '0;
		padoe      <= '0;
		padin_meta <= '0;
		padin_sync <= '0;
	end else begin
		padin_meta <= padin;
		padin_sync <= padin_meta;
		if (wen && offset == riscboy_pkg::GPIO_OUT)
			padout <= apbs_req.pwdata[N_PADS-1:0];
		if (wen && offset == riscboy_pkg::GPIO_OE)
			padoe <= apbs_req.pwdata[N_PADS-1:0];
	end
end

// Read data is zero-extended to the bus width
always_comb begin
	apbs_resp.prdata  = '0;
	apbs_resp.pready  = 1'b1;
	apbs_resp.pslverr = bad_access;
	case (offset)
		riscboy_pkg::GPIO_OUT: apbs_resp.prdata[N_PADS-1:0] = padout;
		riscboy_pkg::GPIO_OE:  apbs_resp.prdata[N_PADS-1:0] = padoe;
		riscboy_pkg::GPIO_IN:  apbs_resp.prdata[N_PADS-1:0] = padin_sync;
		default:               apbs_resp.prdata = '0;
	endcase
end

// Zero wait states rely on the access cycle following its setup cycle directly
assert property (@(posedge clk_sys) disable iff (rst)
	apbs_req.psel && !apbs_req.penable |=>
		apbs_req.psel && apbs_req.penable && $stable(apbs_req.paddr))
	else $error("gpio: setup cycle not followed by its access cycle");

endmodule

`default_nettype wire

// File: hdl/apb_splitter.sv
// ==============================
// APB splitter, decodes paddr[15:12] and routes
// each transfer to GPIO, PWM, management port or error
// ==============================

`timescale 1ns/1ps
`default_nettype none

module apb_splitter (
	// Assertion sampling clock only, the decode itself is combinational
	input  wire                   clk_sys,

	input  riscboy_pkg::apb_req_t  apbs_req,
	output riscboy_pkg::apb_resp_t apbs_resp,

	output riscboy_pkg::apb_req_t  gpio_req,
	input  riscboy_pkg::apb_resp_t gpio_resp,

	output riscboy_pkg::apb_req_t  pwm_req,
	input  riscboy_pkg::apb_resp_t pwm_resp,

	output riscboy_pkg::apb_req_t  tbio_req,
	input  riscboy_pkg::apb_resp_t tbio_resp
);

// ==============================
// Slot decode
// ==============================

logic [3:0] slot;
logic       hit_gpio;
logic       hit_pwm;
logic       hit_tbio;

assign slot     = apbs_req.paddr[15:12];
assign hit_gpio = slot == riscboy_pkg::SLOT_GPIO;
assign hit_pwm  = slot == riscboy_pkg::SLOT_PWM;
assign hit_tbio = slot == riscboy_pkg::SLOT_TBIO;

// Address, strobes and write data go to every slot, only psel is gated
always_comb begin
	gpio_req      = apbs_req;
	pwm_req       = apbs_req;
	tbio_req      = apbs_req;
	gpio_req.psel = apbs_req.psel && hit_gpio;
	pwm_req.psel  = apbs_req.psel && hit_pwm;
	tbio_req.psel = apbs_req.psel && hit_tbio;
end

// ==============================
// Response mux
// ==============================

always_comb begin
	if (hit_gpio) begin
		apbs_resp = gpio_resp;
	end else if (hit_pwm) begin
		apbs_resp = pwm_resp;
	end else if (hit_tbio) begin
		apbs_resp = tbio_resp;
	end else begin
		// Unmapped slots finish at once with an error and no data
		apbs_resp.prdata  = '0;
		apbs_resp.pready  = 1'b1;
		apbs_resp.pslverr = 1'b1;
	end
end

// ==============================
// Assertions
// ==============================

// While a slot stalls the access cycle the master keeps the request frozen
assert property (@(posedge clk_sys)
	apbs_req.psel && apbs_req.penable && !apbs_resp.pready |=>
		apbs_req.psel && apbs_req.penable && $stable(apbs_req.paddr) &&
		$stable(apbs_req.pwrite) && $stable(apbs_req.pwdata))
	else $error("apb_splitter: request changed during a wait state");

endmodule

`default_nettype wire

// File: hdl/riscboy_pkg.sv
// ==============================
// Peripheral bus package with the APB structs,
// the slot address map and the register offsets
// ==============================

`default_nettype none

package riscboy_pkg;

// ==============================
// Bus widths
// ==============================

localparam int W_PADDR = 16;
localparam int W_DATA  = 32;

// Counter, divider and compare width of the backlight PWM
localparam int W_PWM   = 8;

// APB request from master to slave
typedef struct packed {
	logic [W_PADDR-1:0] paddr;
	logic               psel;
	logic               penable;
	logic               pwrite;
	logic [W_DATA-1:0]  pwdata;
} apb_req_t;

// APB response from slave to master
typedef struct packed {
	logic [W_DATA-1:0]  prdata;
	logic               pready;
	logic               pslverr;
} apb_resp_t;

// ==============================
// Address map
// ==============================

// Slot select is paddr[15:12]
localparam logic [3:0] SLOT_GPIO = 4'h0;
localparam logic [3:0] SLOT_PWM  = 4'h1;
localparam logic [3:0] SLOT_TBIO = 4'hf;

// Register offsets within a slot, paddr[11:0]
localparam logic [11:0] GPIO_OUT = 12'h000;
localparam logic [11:0] GPIO_OE  = 12'h004;
localparam logic [11:0] GPIO_IN  = 12'h008;

localparam logic [11:0] PWM_CTRL = 12'h000;
localparam logic [11:0] PWM_DIV  = 12'h004;
localparam logic [11:0] PWM_CMP  = 12'h008;

// Bit positions inside PWM_CTRL
localparam int PWM_CTRL_EN_BIT  = 0;
localparam int PWM_CTRL_INV_BIT = 1;

endpackage

`default_nettype wire
